//--- common/framer_defs.svh
`ifndef FRAMER_DEFS_SVH
`define FRAMER_DEFS_SVH

// width of one stream word
`define FRAMER_DATA_W 32

// payload words carried by every frame
`define FRAMER_PAYLOAD_LEN 4

// payload index width, wide enough for the payload length
`define FRAMER_CNT_W 8

// tag placed in the upper half of each header word
`define FRAMER_MAGIC 16'hF0A5

`endif

//--- common/framer_pkg.sv
`include "framer_defs.svh"

package framer_pkg;

    // one word on the input or output stream
    typedef logic [`FRAMER_DATA_W-1:0] data_t;

    // frame sequence number
    // wraps modulo 65536
    typedef logic [15:0] seq_t;

    // index of the payload word inside the current frame
    typedef logic [`FRAMER_CNT_W-1:0] count_t;

    // framer core phases, one output word per header and trailer
    typedef enum logic [1:0] {
        ST_HEADER  = 2'd0,
        ST_PAYLOAD = 2'd1,
        ST_TRAILER = 2'd2
    } frame_state_t;

endpackage

//--- hw/pipe_regs.sv
`timescale 1ns/10ps

module pipe_regs #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // upstream side
    input  logic                  i_valid,
    output logic                  o_in_ready,
    // downstream side
    output logic                  o_valid,
    input  logic                  i_out_ready,
    // word path
    input  logic [DATA_WIDTH-1:0] i_data,
    output logic [DATA_WIDTH-1:0] o_data
);

    // empty holds nothing, busy holds the output reg, full holds both regs
    // the skid reg is never occupied alone
    typedef enum logic [1:0] {
        EMPTY = 2'd0,
        BUSY  = 2'd1,
        FULL  = 2'd2
    } pipe_state_t;

    pipe_state_t           state;
    pipe_state_t           state_next;
    logic [DATA_WIDTH-1:0] skid_data;
    logic                  insert;
    logic                  remove;
    logic                  load;
    logic                  flow;
    logic                  fill;
    logic                  flush;
    logic                  unload;
    logic                  out_wren;
    logic                  skid_wren;

    // handshake events on each side
    assign insert = i_valid && o_in_ready;
    assign remove = o_valid && i_out_ready;

    // load puts a word into an empty output reg
    assign load   = (state == EMPTY) && insert && !remove;
    // flow replaces the output word as it leaves
    assign flow   = (state == BUSY) && insert && remove;
    // fill parks the new word in the skid reg while the output stalls
    assign fill   = (state == BUSY) && insert && !remove;
    // flush moves the skid word forward
    assign flush  = (state == FULL) && !insert && remove;
    // unload drains the last word
    assign unload = (state == BUSY) && !insert && remove;

    always_comb begin
        state_next = state;
        if (load || flow || flush) begin
            state_next = BUSY;
        end
        if (fill) begin
            state_next = FULL;
        end
        if (unload) begin
            state_next = EMPTY;
        end
    end

    assign out_wren  = load || flow || flush;
    assign skid_wren = fill;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EMPTY;
        end else begin
            state <= state_next;
        end
    end

    // ready and valid come straight from flops, both sides stay isolated
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_in_ready <= 1'b1;
            o_valid    <= 1'b0;
        end else begin
            o_in_ready <= (state_next != FULL);
            o_valid    <= (state_next != EMPTY);
        end
    end

    // skid reg only ever captures the input word
    always_ff @(posedge clk) begin
        if (skid_wren) begin
            skid_data <= i_data;
        end
    end

    // output reg takes the skid word on flush, else the input word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_data <= '0;
        end else if (out_wren) begin
            o_data <= flush ? skid_data : i_data;
        end
    end

endmodule

//--- hw/framer/frame_fsm.sv
`timescale 1ns/10ps

module frame_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    // payload words from the input buffer
    input  logic                    i_pay_valid,
    output logic                    o_pay_ready,
    // framed words towards the output buffer
    output logic                    o_fr_valid,
    input  logic                    i_fr_ready,
    // from the counter
    input  logic                    i_last,
    // steering for the data modules
    output framer_pkg::frame_state_t o_state,
    output logic                    o_count_en,
    output logic                    o_seq_en,
    output logic                    o_acc_en,
    output logic                    o_acc_clr
);

    framer_pkg::frame_state_t state;
    framer_pkg::frame_state_t state_next;
    logic                     xfer;

    // header and trailer are generated here, payload waits for the input
    assign o_fr_valid  = (state == framer_pkg::ST_PAYLOAD) ? i_pay_valid : 1'b1;
    // a payload word is only taken when the output buffer can accept it
    assign o_pay_ready = (state == framer_pkg::ST_PAYLOAD) && i_fr_ready;

    assign xfer = o_fr_valid && i_fr_ready;

    // one pulse per accepted word, by phase
    assign o_acc_clr  = xfer && (state == framer_pkg::ST_HEADER);
    assign o_count_en = xfer && (state == framer_pkg::ST_PAYLOAD);
    assign o_acc_en   = xfer && (state == framer_pkg::ST_PAYLOAD);
    assign o_seq_en   = xfer && (state == framer_pkg::ST_TRAILER);

    always_comb begin
        state_next = state;
        case (state)
            framer_pkg::ST_HEADER: begin
                if (xfer) begin
                    state_next = framer_pkg::ST_PAYLOAD;
                end
            end
            framer_pkg::ST_PAYLOAD: begin
                // stay here until the last payload word leaves
                if (xfer && i_last) begin
                    state_next = framer_pkg::ST_TRAILER;
                end
            end
            framer_pkg::ST_TRAILER: begin
                if (xfer) begin
                    state_next = framer_pkg::ST_HEADER;
                end
            end
            default: begin
                state_next = framer_pkg::ST_HEADER;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= framer_pkg::ST_HEADER;
        end else begin
            state <= state_next;
        end
    end

    assign o_state = state;

endmodule

//--- hw/framer/frame_counter.sv
`timescale 1ns/10ps
`include "framer_defs.svh"

module frame_counter (
    input  logic             clk,
    input  logic             rst_n,
    // one pulse per payload word sent
    input  logic             i_count_en,
    // one pulse per trailer sent
    input  logic             i_seq_en,
    output logic             o_last,
    output framer_pkg::seq_t o_seq
);

    // index of the last payload word in a frame
    localparam framer_pkg::count_t LAST_IDX = framer_pkg::count_t'(`FRAMER_PAYLOAD_LEN - 1);

    framer_pkg::count_t idx;
    framer_pkg::seq_t   seq;

    assign o_last = (idx == LAST_IDX);

    // payload index, back to zero once the frame's payload is done
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idx <= '0;
        end else if (i_count_en) begin
            if (o_last) begin
                idx <= '0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // sequence steps after each trailer, wraps naturally at 16 bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq <= '0;
        end else if (i_seq_en) begin
            seq <= seq + 1'b1;
        end
    end

    assign o_seq = seq;

endmodule

//--- hw/framer/frame_word_mux.sv
`timescale 1ns/10ps
`include "framer_defs.svh"

module frame_word_mux (
    input  logic                     clk,
    input  logic                     rst_n,
    input  framer_pkg::frame_state_t i_state,
    input  framer_pkg::data_t        i_pay_data,
    input  framer_pkg::seq_t         i_seq,
    // accumulate on payload transfer
    input  logic                     i_acc_en,
    // clear on header transfer
    input  logic                     i_acc_clr,
    output framer_pkg::data_t        o_fr_data
);

    framer_pkg::data_t checksum;
    framer_pkg::data_t header_word;

    // running xor over the current frame's payload
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            checksum <= '0;
        end else if (i_acc_clr) begin
            checksum <= '0;
        end else if (i_acc_en) begin
            checksum <= checksum ^ i_pay_data;
        end
    end

    // magic tag on top, sequence number below
    assign header_word = {`FRAMER_MAGIC, i_seq};

    // purely combinational from the phase
    always_comb begin
        case (i_state)
            framer_pkg::ST_HEADER: begin
                o_fr_data = header_word;
            end
            framer_pkg::ST_PAYLOAD: begin
                o_fr_data = i_pay_data;
            end
            default: begin
                o_fr_data = checksum;
            end
        endcase
    end

endmodule

//--- hw/stream_framer_top.sv
`timescale 1ns/10ps
`include "framer_defs.svh"

module stream_framer_top (
    input  logic              clk,
    input  logic              rst_n,
    // input stream
    input  logic              i_valid,
    output logic              o_in_ready,
    input  framer_pkg::data_t i_data,
    // framed output stream
    output logic              o_valid,
    input  logic              i_ready,
    output framer_pkg::data_t o_data
);

    // input buffer to core
    logic                     pay_valid;
    logic                     pay_ready;
    framer_pkg::data_t        pay_data;
    // core to output buffer
    logic                     fr_valid;
    logic                     fr_ready;
    framer_pkg::data_t        fr_data;
    // inside the core
    framer_pkg::frame_state_t state;
    framer_pkg::seq_t         seq;
    logic                     last;
    logic                     count_en;
    logic                     seq_en;
    logic                     acc_en;
    logic                     acc_clr;

    pipe_regs #(
        .DATA_WIDTH (`FRAMER_DATA_W)
    ) in_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid     (i_valid),
        .o_in_ready  (o_in_ready),
        .o_valid     (pay_valid),
        .i_out_ready (pay_ready),
        .i_data      (i_data),
        .o_data      (pay_data)
    );

    frame_fsm frame_fsm_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_pay_valid (pay_valid),
        .o_pay_ready (pay_ready),
        .o_fr_valid  (fr_valid),
        .i_fr_ready  (fr_ready),
        .i_last      (last),
        .o_state     (state),
        .o_count_en  (count_en),
        .o_seq_en    (seq_en),
        .o_acc_en    (acc_en),
        .o_acc_clr   (acc_clr)
    );

    frame_counter frame_counter_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_count_en (count_en),
        .i_seq_en   (seq_en),
        .o_last     (last),
        .o_seq      (seq)
    );

    frame_word_mux frame_word_mux_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_state    (state),
        .i_pay_data (pay_data),
        .i_seq      (seq),
        .i_acc_en   (acc_en),
        .i_acc_clr  (acc_clr),
        .o_fr_data  (fr_data)
    );

    // output buffer registers the framed word and decouples i_ready
    pipe_regs #(
        .DATA_WIDTH (`FRAMER_DATA_W)
    ) out_buf (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_valid     (fr_valid),
        .o_in_ready  (fr_ready),
        .o_valid     (o_valid),
        .i_out_ready (i_ready),
        .i_data      (fr_data),
        .o_data      (o_data)
    );

endmodule

//--- verification/stream_framer_assertions.sv
`timescale 1ns/10ps

module stream_framer_assertions #(
    parameter int DATA_WIDTH      = 32,
    // frame_fsm drives a combinational valid, which is high in reset
    parameter bit VALID_FROM_FLOP = 1'b1
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  valid,
    input logic                  ready,
    input logic [DATA_WIDTH-1:0] data,
    input logic [1:0]            state
);

    logic in_reset_d;

    // set once reset has been seen at a clock edge
    always_ff @(posedge clk) begin
        in_reset_d <= !rst_n;
    end

    // a stalled word keeps its valid and its value
    hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        valid && !ready |=> valid && $stable(data))
        else $error("valid dropped or data changed while stalled");

    // both state enums use codes 0 to 2
    state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state != 2'd3)
        else $error("illegal state code");

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n && in_reset_d && VALID_FROM_FLOP |-> !valid)
        else $error("valid high during reset");

endmodule

bind pipe_regs stream_framer_assertions #(
    .DATA_WIDTH (DATA_WIDTH)
) pipe_regs_checks (
    .clk   (clk),
    .rst_n (rst_n),
    .valid (o_valid),
    .ready (i_out_ready),
    .data  (o_data),
    .state (state)
);

// the phase must hold while the framed word is stalled
bind frame_fsm stream_framer_assertions #(
    .DATA_WIDTH      (2),
    .VALID_FROM_FLOP (1'b0)
) frame_fsm_checks (
    .clk   (clk),
    .rst_n (rst_n),
    .valid (o_fr_valid),
    .ready (i_fr_ready),
    .data  (o_state),
    .state (state)
);

//--- verification/stream_framer_tb.sv
`timescale 1ns/10ps
`include "framer_defs.svh"

module stream_framer_tb;

    localparam int PAY          = `FRAMER_PAYLOAD_LEN;
    localparam int FRAME_WORDS  = PAY + 2;
    localparam int FRAMES       = 8;
    localparam int N_TESTS      = 4;
    localparam int STALL_FACTOR = 16;
    localparam int RESET_CYCLES = 8;
    // every stream test gets a generous number of cycles per frame word
    localparam int TIMEOUT_CYCLES = N_TESTS * FRAMES * FRAME_WORDS * STALL_FACTOR
                                    + 4 * RESET_CYCLES;

    logic              clk;
    logic              rst_n;
    logic              i_valid;
    logic              o_in_ready;
    framer_pkg::data_t i_data;
    logic              o_valid;
    logic              i_ready;
    framer_pkg::data_t o_data;

    logic [31:0]       lfsr;
    // words accepted at the input and not yet seen at the output
    framer_pkg::data_t in_q[$];
    int                in_count;
    int                out_count;
    int                frames_done;
    int                frame_pos;
    int                checks;
    int                errors;
    int                tests;
    framer_pkg::seq_t  exp_seq;
    framer_pkg::data_t exp_xor;

    stream_framer_top stream_framer_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (i_valid),
        .o_in_ready (o_in_ready),
        .i_data     (i_data),
        .o_valid    (o_valid),
        .i_ready    (i_ready),
        .o_data     (o_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] val);
        int k;
        val = '0;
        for (k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            val  = {val[30:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input string name, input framer_pkg::data_t exp,
                              input framer_pkg::data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_seq(input string name, input framer_pkg::seq_t exp,
                             input framer_pkg::seq_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    // reference model stepping through header, payload and trailer per output word
    task automatic check_output();
        framer_pkg::data_t w;
        if (frame_pos == 0) begin
            check_word("o_data header", {`FRAMER_MAGIC, exp_seq}, o_data);
            check_seq("o_data header seq", exp_seq, o_data[15:0]);
            exp_xor   = '0;
            frame_pos = 1;
        end else if (frame_pos <= PAY) begin
            if (in_q.size() == 0) begin
                errors++;
                $display("error at %0t: payload word came out with no input word left", $time);
            end else begin
                w = in_q.pop_front();
                check_word("o_data payload", w, o_data);
                exp_xor = exp_xor ^ w;
            end
            frame_pos++;
        end else begin
            check_word("o_data trailer", exp_xor, o_data);
            exp_seq   = exp_seq + 16'd1;
            frame_pos = 0;
            frames_done++;
        end
        out_count++;
    endtask

    // both handshakes are sampled at the rising edge where the inputs are stable
    always @(posedge clk) begin
        if (rst_n) begin
            if (i_valid && o_in_ready) begin
                in_q.push_back(i_data);
                in_count++;
            end
            if (o_valid && i_ready) begin
                check_output();
            end
        end
    end

    task automatic reset_test();
        int checks_0;
        int errors_0;
        checks_0 = checks;
        errors_0 = errors;
        rst_n    = 1'b0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_flag("o_valid", 1'b0, o_valid);
        end
        rst_n = 1'b1;
        // input side already open before the first normal edge
        check_flag("o_in_ready", 1'b1, o_in_ready);
        tests++;
        $display("test %-16s %0d checks, %0d errors", "reset", checks - checks_0,
                 errors - errors_0);
    endtask

    // sends FRAMES frames of payload with optional input gaps and output stalls
    task automatic run_test(input string name, input bit gaps, input bit stalls);
        int          checks_0;
        int          errors_0;
        int          presented;
        int          limit;
        int          target;
        logic [31:0] r;
        checks_0  = checks;
        errors_0  = errors;
        presented = in_count;
        limit     = in_count + FRAMES * PAY;
        target    = frames_done + FRAMES;
        while (frames_done < target) begin
            @(negedge clk);
            // next word only after the previous one was taken
            if (in_count == presented) begin
                i_valid = 1'b0;
                if (presented < limit) begin
                    rand_bits(1, r);
                    if (!gaps || r[0]) begin
                        rand_bits(32, r);
                        i_data  = r;
                        i_valid = 1'b1;
                        presented++;
                    end
                end
            end
            if (stalls) begin
                // sink ready about three cycles in four
                rand_bits(2, r);
                i_ready = (r[1:0] != 2'b00);
            end else begin
                i_ready = 1'b1;
            end
        end
        @(negedge clk);
        i_valid = 1'b0;
        i_ready = 1'b1;
        // the next header may already be out but nothing past it
        if (in_q.size() != 0 || frame_pos > 1) begin
            errors++;
            $display("error at %0t: test %s ended with input words left or a frame open",
                     $time, name);
        end
        tests++;
        $display("test %-16s %0d checks, %0d errors", name, checks - checks_0,
                 errors - errors_0);
    endtask

    initial begin
        lfsr        = 32'he824_8bbd;
        rst_n       = 1'b0;
        i_valid     = 1'b0;
        i_data      = '0;
        i_ready     = 1'b1;
        in_count    = 0;
        out_count   = 0;
        frames_done = 0;
        frame_pos   = 0;
        checks      = 0;
        errors      = 0;
        tests       = 0;
        exp_seq     = '0;
        exp_xor     = '0;
        reset_test();
        run_test("steady", 1'b0, 1'b0);
        run_test("input_gaps", 1'b1, 1'b0);
        run_test("output_stalls", 1'b0, 1'b1);
        run_test("gaps_and_stalls", 1'b1, 1'b1);
        $display("summary: %0d tests, %0d checks, %0d errors, %0d words out", tests, checks,
                 errors, out_count);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: output stalled after %0d words", out_count);
        $display(">>> FAIL");
        $finish;
    end

endmodule

//--- sim.f
+incdir+common
common/framer_pkg.sv
hw/pipe_regs.sv
hw/framer/frame_fsm.sv
hw/framer/frame_counter.sv
hw/framer/frame_word_mux.sv
hw/stream_framer_top.sv
verification/stream_framer_assertions.sv
verification/stream_framer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module stream_framer_tb -f sim.f -o stream_framer_sim

./obj_dir/stream_framer_sim | tee sim.log

if grep -qx ">>> PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
